//--- all.f
+incdir+source
source/px_pkg.sv
source/px_strob_if.sv
source/px_state_reg.sv
source/px_strob_seq.sv
source/px_bus_ctl.sv
source/px_top.sv
tests/px_properties.sv
tests/px_tb.sv

//--- Bender.yml
package:
  name: px_cycle_ctl

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/px_pkg.sv
      - source/px_strob_if.sv
      - source/px_state_reg.sv
      - source/px_strob_seq.sv
      - source/px_bus_ctl.sv
      - source/px_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/px_properties.sv
      - tests/px_tb.sv

//--- tests/px_tb.sv
// Testbench for the cycle-state control
// LFSR stimulus, bus responder, reference model and compare process
`timescale 1ns/10ps
`include "px_defines.svh"

module px_tb;

	import px_pkg::*;

	localparam cycle_state_t P0_ONLY = 16'h1 << `PX_P0_BIT;

	logic         got;
	logic         clo_;
	cycle_state_t enter;
	logic         mode;
	logic         step_;
	logic         zw;
	logic         rok_;
	logic         stop_;
	cycle_state_t state_;
	logic         strob1;
	logic         strob2;
	logic         cycle_end;
	logic         zg;
	logic         rd_en_;
	logic         wr_en_;
	logic         awaria_;

	logic [31:0]  lfsr = 32'h141b;  // Random source
	cycle_state_t cur;              // Model of active states
	int           s1_cnt;           // strob1 cycles this cycle
	int           s2_cnt;
	int           zg_cnt;           // Request cycles this cycle
	int           n_end;            // cycle_end pulses seen
	logic         replied;
	logic         timed_out;
	logic         fail_m;           // Model of failure latch
	logic         reply_on;         // Responder answers requests
	int           reply_dly;        // Request cycles before rok_ low
	int           zw_hold;          // Request cycles with zw low
	int           zg_seen;

	// P0, P4, P2, K2 read, WW write, P0 P3 WX, no state at all
	cycle_state_t dir_vec [7] = '{
		16'h0004, 16'h0040, 16'h0010, 16'h0002, 16'h0200, 16'h0824, 16'h0000
	};

	px_top i_px_top (.*);

	initial begin
		got = 1'b0;
		forever #10 got = ~got;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s: got %h expected %h", name, act, exp));
		end
	endtask

	// Failures counted by the bound checkers
	function automatic int prop_fails();
		return i_px_top.i_strob_seq.i_seq_props.n_fail +
			i_px_top.i_bus_ctl.i_bus_props.n_fail;
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[31]};
		end
	endtask

	// Expected STROB1 length, largest tick count of the active groups
	function automatic int s1_len(input cycle_state_t s);
		cycle_state_t msk [5];
		int           tck [5];
		int           len;
		msk = '{`PX_G1_MASK, `PX_G2_MASK, `PX_G3_MASK, `PX_G4_MASK, `PX_G5_MASK};
		tck = '{`PX_STROB1_G1_TICKS, `PX_STROB1_G2_TICKS, `PX_STROB1_G3_TICKS,
			`PX_STROB1_G4_TICKS, `PX_STROB1_G5_TICKS};
		len = 0;
		for (int g = 0; g < 5; g++) begin
			if ((s & msk[g]) != 0 && tck[g] > len) begin
				len = tck[g];
			end
		end
		return (len == 0) ? tck[0] : len;    // Nothing active, group 1 length
	endfunction

	// Expected {bus, read, write} flags
	function automatic logic [2:0] cyc_flags(input cycle_state_t s);
		return {|(s & `PX_BUS_MASK), |(s & `PX_READ_MASK), |(s & `PX_WRITE_MASK)};
	endfunction

	task automatic wait_end();
		int n;
		n = 0;
		do begin
			@(negedge got);
			n++;
			if (n > 100) begin
				abort_run("Timeout: no end of cycle within 100 clocks");
			end
		end while (!cycle_end);
	endtask

	// Next state vector and its bus timing, presented during END
	task automatic end_cycle(input cycle_state_t vec);
		logic [31:0] r;
		wait_end();
		rand_bits(4, r);
		reply_dly = r;
		rand_bits(2, r);
		zw_hold = r;
		enter <= vec;
	endtask

	task automatic draw_state(output cycle_state_t v);
		logic [31:0] r;
		rand_bits(17, r);
		v = r[16] ? r[15:0] & ~`PX_BUS_MASK : r[15:0];    // Some cycles off the bus
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge got);
			if (strob1 || cycle_end) begin
				abort_run("Step mode ran a cycle without a step pulse");
			end
		end
	endtask

	// Bus responder
	always @(negedge got) begin
		if (zg && reply_on) begin
			zw      <= zg_seen >= zw_hold;
			rok_    <= zg_seen < reply_dly;
			zg_seen = zg_seen + 1;
		end else begin
			zw      <= 1'b1;
			rok_    <= 1'b1;
			zg_seen = 0;
		end
	end

	// Compare process, values as the DUT samples them at this edge
	always @(posedge got) begin
		logic [2:0] fl;
		logic       ezg;
		logic       fire;
		if (!clo_) begin
			cur       = P0_ONLY;
			s1_cnt    = 0;
			s2_cnt    = 0;
			zg_cnt    = 0;
			n_end     = 0;
			replied   = 1'b0;
			timed_out = 1'b0;
			fail_m    = 1'b0;
		end else begin
			fl   = cyc_flags(cur);
			ezg  = strob1 && fl[2] && !replied && !timed_out;
			fire = 1'b0;
			if (prop_fails() != 0) begin
				abort_run("An assertion in a bound checker failed");
			end
			check_val("state_", state_, cycle_state_t'(~cur));
			check_val("zg", zg, ezg);
			check_val("rd_en_", rd_en_, !(ezg && zw && fl[1]));
			check_val("wr_en_", wr_en_, !(ezg && zw && fl[0]));
			check_val("awaria_", awaria_, !fail_m);
			s1_cnt += strob1;
			s2_cnt += strob2;
			if (ezg) begin
				zg_cnt++;
				if (zw && !rok_) begin
					replied = 1'b1;
				end else if (zg_cnt == `PX_ALARM_TICKS) begin
					timed_out = 1'b1;               // Alarm fires at this edge
					fire      = 1'b1;
				end
			end
			if (!stop_) begin
				fail_m = 1'b0;
			end else if (fire) begin
				fail_m = 1'b1;
			end
			if (cycle_end) begin
				if (!fl[2]) begin
					check_val("strob1 length", s1_cnt, s1_len(cur));
				end else if (s1_cnt < s1_len(cur) || !(replied || timed_out)) begin
					abort_run("Bus cycle left strob1 early or without reply or alarm");
				end
				check_val("strob2 length", s2_cnt, `PX_STROB2_TICKS);
				cur       = enter;               // Loaded at this edge
				n_end++;
				s1_cnt    = 0;
				s2_cnt    = 0;
				zg_cnt    = 0;
				replied   = 1'b0;
				timed_out = 1'b0;
			end
		end
	end

	initial begin
		cycle_state_t v;
		int           n0;
		clo_      = 1'b0;
		enter     = '0;
		mode      = 1'b0;
		step_     = 1'b1;
		zw        = 1'b1;
		rok_      = 1'b1;
		stop_     = 1'b1;
		reply_on  = 1'b1;
		reply_dly = 0;
		zw_hold   = 0;
		repeat (4) @(negedge got);
		check_val("state_", state_, cycle_state_t'(~P0_ONLY));
		check_val("strob1 strob2 cycle_end zg rd_en_ wr_en_ awaria_",
			{strob1, strob2, cycle_end, zg, rd_en_, wr_en_, awaria_}, 7'b0000111);
		clo_ <= 1'b1;
		foreach (dir_vec[i]) begin
			end_cycle(dir_vec[i]);
		end
		repeat (60) begin
			draw_state(v);
			end_cycle(v);
		end
		mode <= 1'b1;                    // IDLE after this END
		repeat (3) begin
			expect_quiet(20);
			n0 = n_end;
			step_ <= 1'b0;
			@(negedge got);
			step_ <= 1'b1;
			draw_state(v);
			end_cycle(v);
			expect_quiet(4);
			check_val("cycle_end count", n_end - n0, 1);
		end
		mode <= 1'b0;
		end_cycle(16'h0100);             // WR with no reply
		reply_on = 1'b0;
		end_cycle(16'h0040);
		reply_on = 1'b1;
		check_val("awaria_", awaria_, 1'b0);
		repeat (2) begin
			draw_state(v);
			end_cycle(v);
		end
		check_val("awaria_", awaria_, 1'b0);    // Latched until stop_
		stop_ <= 1'b0;
		@(negedge got);
		stop_ <= 1'b1;
		@(negedge got);
		check_val("awaria_", awaria_, 1'b1);
		repeat (5) begin
			draw_state(v);
			end_cycle(v);
		end
		if (prop_fails() != 0) begin
			abort_run("An assertion in a bound checker failed");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- tests/px_properties.sv
// Concurrent assertions on the strobes and the bus request
// Bound into the sequencer and the bus control
`timescale 1ns/10ps

module px_properties (
	input logic got,
	input logic clo_,
	input logic strob1,
	input logic strob2,
	input logic cycle_end,
	input logic zg,          // Tied low in the sequencer
	input logic bus_done,
	input logic alarm
);

	int n_fail = 0;          // Failed assertions so far

	a_strob_excl: assert property (@(posedge got) disable iff (!clo_)
		!(strob1 && strob2))
		else begin
			$error("strob1 and strob2 high together");
			n_fail++;
		end

	a_end_one: assert property (@(posedge got) disable iff (!clo_)
		cycle_end |=> !cycle_end)
		else begin
			$error("cycle_end longer than one cycle");
			n_fail++;
		end

	// Request drops only on reply or alarm
	a_zg_fall: assert property (@(posedge got) disable iff (!clo_)
		$fell(zg) |-> (bus_done || alarm))
		else begin
			$error("zg fell without a reply or an alarm");
			n_fail++;
		end

endmodule

bind px_strob_seq px_properties i_seq_props (
	.got       (got),
	.clo_      (clo_),
	.strob1    (sif.strob1),
	.strob2    (sif.strob2),
	.cycle_end (sif.cycle_end),
	.zg        (1'b0),
	.bus_done  (sif.bus_done),
	.alarm     (sif.alarm)
);

bind px_bus_ctl px_properties i_bus_props (
	.got       (got),
	.clo_      (clo_),
	.strob1    (sif.strob1),
	.strob2    (1'b0),
	.cycle_end (sif.cycle_end),
	.zg        (zg),
	.bus_done  (sif.bus_done),
	.alarm     (sif.alarm)
);

//--- source/px_top.sv
// Cycle-state control top level
// State register, strobe sequencer and bus control
`timescale 1ns/10ps

module px_top (
	input  logic                  got,
	input  logic                  clo_,
	input  px_pkg::cycle_state_t  enter,       // Enter-state lines
	input  logic                  mode,        // Step mode when high
	input  logic                  step_,       // Step pulse
	input  logic                  zw,          // Bus grant
	input  logic                  rok_,        // Bus reply
	input  logic                  stop_,       // Failure clear
	output px_pkg::cycle_state_t  state_,      // Active-low states
	output logic                  strob1,
	output logic                  strob2,
	output logic                  cycle_end,
	output logic                  zg,          // Bus request
	output logic                  rd_en_,
	output logic                  wr_en_,
	output logic                  awaria_
);

	px_pkg::cycle_state_t state;     // Active-high states
	px_pkg::tick_t        s1_ticks;  // STROB1 length
	logic                 bus_cycle;
	logic                 rd_cycle;
	logic                 wr_cycle;

	px_strob_if sif ();

	px_state_reg i_state_reg (
		.got          (got),
		.clo_         (clo_),
		.enter        (enter),
		.cycle_end    (sif.cycle_end),
		.state        (state),
		.strob1_ticks (s1_ticks),
		.bus_cycle    (bus_cycle),
		.rd_cycle     (rd_cycle),
		.wr_cycle     (wr_cycle)
	);

	px_strob_seq i_strob_seq (
		.got          (got),
		.clo_         (clo_),
		.mode         (mode),
		.step_        (step_),
		.strob1_ticks (s1_ticks),
		.bus_cycle    (bus_cycle),
		.sif          (sif.seq)
	);

	px_bus_ctl i_bus_ctl (
		.got       (got),
		.clo_      (clo_),
		.bus_cycle (bus_cycle),
		.rd_cycle  (rd_cycle),
		.wr_cycle  (wr_cycle),
		.zw        (zw),
		.rok_      (rok_),
		.stop_     (stop_),
		.sif       (sif.bus),
		.zg        (zg),
		.rd_en_    (rd_en_),
		.wr_en_    (wr_en_),
		.awaria_   (awaria_)
	);

	assign state_    = ~state;    // Outputs are active low
	assign strob1    = sif.strob1;
	assign strob2    = sif.strob2;
	assign cycle_end = sif.cycle_end;

endmodule

//--- source/px_bus_ctl.sv
// Bus request, reply latch, alarm timer and failure flag
// Read and write driver enables
`timescale 1ns/10ps
`include "px_defines.svh"

module px_bus_ctl (
	input  logic     got,
	input  logic     clo_,
	input  logic     bus_cycle,   // Active state uses the bus
	input  logic     rd_cycle,    // Bus read state
	input  logic     wr_cycle,    // Bus write state
	input  logic     zw,          // Bus granted to CPU
	input  logic     rok_,        // Bus reply, active low
	input  logic     stop_,       // Clears failure flag
	px_strob_if.bus  sif,
	output logic     zg,          // Bus request
	output logic     rd_en_,      // Read driver enable
	output logic     wr_en_,      // Write driver enable
	output logic     awaria_      // Failure flag, active low
);

	import px_pkg::*;

	localparam tick_t ALARM_LAST = `PX_ALARM_TICKS - 8'd1;

	tick_t al_cnt;     // Cycles with zg high
	logic  done_q;     // Reply latched
	logic  tout_q;     // Alarm fired in this cycle
	logic  alarm_q;    // Alarm pulse
	logic  fail_q;     // Failure latch
	logic  reply;      // Reply accepted now
	logic  fire;       // Alarm fires at this edge
	logic  zwzg;       // Request granted

	// Request from first STROB1 cycle until reply or alarm
	assign zg    = sif.strob1 & bus_cycle & ~done_q & ~tout_q;
	assign zwzg  = zg & zw;
	assign reply = zwzg & ~rok_;
	assign fire  = zg & ~reply & (al_cnt == ALARM_LAST);   // Reply wins a tie

	// Alarm timer runs whether granted or not
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			al_cnt <= '0;
		end else if (!zg) begin
			al_cnt <= '0;
		end else begin
			al_cnt <= al_cnt + 1'b1;
		end
	end

	// Reply and timeout held to end of cycle
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			done_q <= 1'b0;
			tout_q <= 1'b0;
		end else if (sif.cycle_end) begin
			done_q <= 1'b0;
			tout_q <= 1'b0;
		end else begin
			if (reply) begin
				done_q <= 1'b1;
			end
			if (fire) begin
				tout_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			alarm_q <= 1'b0;
		end else begin
			alarm_q <= fire;    // One cycle wide
		end
	end

	// Failure latch, stop_ clears
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			fail_q <= 1'b0;
		end else if (!stop_) begin
			fail_q <= 1'b0;
		end else if (fire) begin
			fail_q <= 1'b1;
		end
	end

	assign sif.bus_done = done_q;
	assign sif.alarm    = alarm_q;

	// Drivers only while request is granted
	assign rd_en_  = ~(zwzg & rd_cycle);
	assign wr_en_  = ~(zwzg & wr_cycle);
	assign awaria_ = ~fail_q;

endmodule

//--- source/px_strob_seq.sv
// Strobe sequencer phase machine
// STROB1, STROB2 and end-of-cycle pulse in run and step modes
`timescale 1ns/10ps
`include "px_defines.svh"

module px_strob_seq (
	input  logic           got,
	input  logic           clo_,
	input  logic           mode,           // High for step mode
	input  logic           step_,          // Step request, active low
	input  px_pkg::tick_t  strob1_ticks,   // Minimum STROB1 length
	input  logic           bus_cycle,      // STROB1 waits for the bus
	px_strob_if.seq        sif
);

	import px_pkg::*;

	localparam tick_t S2_TICKS = `PX_STROB2_TICKS;

	strob_phase_t phase;        // Current phase
	strob_phase_t phase_nx;     // Next phase
	tick_t        cnt;          // Cycles spent in phase
	logic         step_q;       // step_ one cycle back
	logic         step_fall;    // Falling edge of step_
	logic         step_req;     // Step seen during a cycle
	logic         alarm_seen;   // Alarm pulse kept until END
	logic         bus_ok;       // Bus wait over
	logic         go;           // Leave IDLE
	logic         s1_done;
	logic         s2_done;

	assign step_fall = step_q & ~step_;
	assign go        = !mode || step_req || step_fall;

	// Bus cycles need a reply or the alarm
	assign bus_ok  = !bus_cycle || sif.bus_done || sif.alarm || alarm_seen;
	assign s1_done = (cnt >= strob1_ticks) && bus_ok;
	assign s2_done = cnt >= S2_TICKS;

	always_comb begin
		phase_nx = phase;
		case (phase)
			IDLE: begin
				if (go) begin
					phase_nx = S1;
				end
			end
			S1: begin
				if (s1_done) begin
					phase_nx = S2;
				end
			end
			S2: begin
				if (s2_done) begin
					phase_nx = END;
				end
			end
			END: begin
				phase_nx = mode ? IDLE : S1;    // Step mode stops after each cycle
			end
			default: begin
				phase_nx = IDLE;
			end
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			phase <= IDLE;
		end else begin
			phase <= phase_nx;
		end
	end

	// Phase length counter, saturating
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cnt <= '0;
		end else if (phase_nx != phase) begin
			cnt <= tick_t'(1);                   // First cycle of new phase
		end else if (cnt != '1) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Step edge detect and pending step
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			step_q   <= 1'b1;
			step_req <= 1'b0;
		end else begin
			step_q <= step_;
			if (!mode || phase == IDLE) begin
				step_req <= 1'b0;               // Consumed on leaving IDLE
			end else if (step_fall) begin
				step_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			alarm_seen <= 1'b0;
		end else if (phase == END) begin
			alarm_seen <= 1'b0;
		end else if (sif.alarm) begin
			alarm_seen <= 1'b1;
		end
	end

	// Strobes decoded from phase
	assign sif.strob1    = phase == S1;
	assign sif.strob2    = phase == S2;
	assign sif.cycle_end = phase == END;

endmodule

//--- source/px_state_reg.sv
// Cycle-state register with STROB1 length decode
// and bus, read and write cycle flags
`timescale 1ns/10ps
`include "px_defines.svh"

module px_state_reg (
	input  logic                  got,
	input  logic                  clo_,
	input  px_pkg::cycle_state_t  enter,          // Enter-state lines
	input  logic                  cycle_end,      // Load strobe
	output px_pkg::cycle_state_t  state,          // Active states
	output px_pkg::tick_t         strob1_ticks,   // Decoded STROB1 length
	output logic                  bus_cycle,      // Some state uses the bus
	output logic                  rd_cycle,       // Bus read state active
	output logic                  wr_cycle        // Bus write state active
);

	import px_pkg::*;

	localparam int           N_GRP     = 5;
	localparam cycle_state_t RST_STATE = cycle_state_t'(1 << `PX_P0_BIT);   // P0 only

	localparam cycle_state_t G_MASK [N_GRP] = '{
		`PX_G1_MASK,
		`PX_G2_MASK,
		`PX_G3_MASK,
		`PX_G4_MASK,
		`PX_G5_MASK
	};

	localparam tick_t G_TICKS [N_GRP] = '{
		`PX_STROB1_G1_TICKS,
		`PX_STROB1_G2_TICKS,
		`PX_STROB1_G3_TICKS,
		`PX_STROB1_G4_TICKS,
		`PX_STROB1_G5_TICKS
	};

	logic [N_GRP-1:0] g_act;    // Group has an active state

	// State flip-flops, loaded at end of cycle
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= RST_STATE;
		end else if (cycle_end) begin
			state <= enter;
		end
	end

	// Which strobe groups are active
	always_comb begin
		for (int g = 0; g < N_GRP; g++) begin
			g_act[g] = |(state & G_MASK[g]);
		end
	end

	// Longest STROB1 among active groups
	always_comb begin
		strob1_ticks = '0;
		for (int g = 0; g < N_GRP; g++) begin
			if (g_act[g] && (G_TICKS[g] > strob1_ticks)) begin
				strob1_ticks = G_TICKS[g];
			end
		end
		if (g_act == '0) begin
			strob1_ticks = G_TICKS[0];    // No state, group 1 length
		end
	end

	// Cycle type flags
	assign bus_cycle = |(state & `PX_BUS_MASK);
	assign rd_cycle  = |(state & `PX_READ_MASK);
	assign wr_cycle  = |(state & `PX_WRITE_MASK);

endmodule

//--- source/px_strob_if.sv
// Strobe and bus-wait signals between sequencer and bus control
`timescale 1ns/10ps

interface px_strob_if;

	logic strob1;       // STROB1 phase
	logic strob2;       // STROB2 phase
	logic cycle_end;    // Last cycle of machine cycle
	logic bus_done;     // Bus reply latched
	logic alarm;        // Missing reply, one-cycle pulse

	// Sequencer side
	modport seq (
		output strob1,
		output strob2,
		output cycle_end,
		input  bus_done,
		input  alarm
	);

	// Bus control side, STROB2 not needed here
	modport bus (
		input  strob1,
		input  cycle_end,
		output bus_done,
		output alarm
	);

endinterface

//--- source/px_pkg.sv
// Shared types of the cycle-state control
// State vector, tick count and sequencer phase
`include "px_defines.svh"

package px_pkg;

	// One bit per cycle state, bit map in the defines header
	typedef logic [`PX_STATES-1:0] cycle_state_t;

	// Count of got cycles
	typedef logic [`PX_TICK_W-1:0] tick_t;

	// Strobe sequencer phases
	typedef enum logic [1:0] {
		IDLE = 2'd0,    // Waiting for step or run
		S1   = 2'd1,    // STROB1 high
		S2   = 2'd2,    // STROB2 high
		END  = 2'd3     // End-of-cycle pulse
	} strob_phase_t;

endpackage

//--- source/px_defines.svh
// Cycle-state control constants
// State bit map, strobe group masks, tick counts, bus masks
`ifndef PX_DEFINES_SVH
`define PX_DEFINES_SVH

// Bits 0..15 are K1 K2 P0 P1 P2 P3 P4 P5 WR WW WM WX I1 I2 I3 I4
`define PX_STATES            16          // Cycle-state flip-flops
`define PX_TICK_W            8           // Width of got-cycle counts
`define PX_P0_BIT            2           // P0 is the reset state

`define PX_G1_MASK           16'h0040    // P4
`define PX_G2_MASK           16'h500b    // K1 K2 P1 I1 I3
`define PX_G3_MASK           16'ha780    // P5 WR WW WM I2 I4
`define PX_G4_MASK           16'h0024    // P0 P3
`define PX_G5_MASK           16'h0810    // P2 WX

`define PX_STROB1_G1_TICKS   8'd2        // Shortest STROB1
`define PX_STROB1_G2_TICKS   8'd3
`define PX_STROB1_G3_TICKS   8'd4
`define PX_STROB1_G4_TICKS   8'd5
`define PX_STROB1_G5_TICKS   8'd6        // Longest STROB1
`define PX_STROB2_TICKS      8'd3        // Fixed STROB2 length

`define PX_ALARM_TICKS       8'd24       // Request cycles before alarm

`define PX_BUS_MASK          16'hf78b    // K1 K2 P1 P5 WR WW WM I1..I4
`define PX_READ_MASK         16'hd18a    // K2 P1 P5 WR I1 I3 I4
`define PX_WRITE_MASK        16'h2600    // WW WM I2

`endif
